/* Bender.yml */
package:
  name: etx_core

sources:
  - include_dirs:
      - .
    files:
      - etx_pkg.sv
      - etx_arbiter.sv
      - etx_cfg.sv
      - etx_remap.sv
      - etx_protocol.sv
      - etx_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - etx_core_tb.sv

/* etx_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module etx_arbiter
   import etx_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  logic          txwr_access,
   input  emesh_packet_t txwr_packet,
   output logic          txwr_wait,
   input  logic          txrd_access,
   input  emesh_packet_t txrd_packet,
   output logic          txrd_wait,
   input  logic          txrr_access,
   input  emesh_packet_t txrr_packet,
   output logic          txrr_wait,
   input  etx_cfg_t      cfg,
   input  logic          etx_rd_wait,
   input  logic          etx_wr_wait,
   output logic          arb_access,
   output emesh_packet_t arb_packet,
   output logic          arb_rr
);

   logic          gate_wr, gate_rd, gate_rr;  // Held off by the enable gate
   logic          elig_wr, elig_rd, elig_rr;  // Requests that may win
   logic          any_req;
   logic          arb_stall;                  // Output register cannot move
   etx_src_e      sel_src;
   emesh_packet_t sel_packet;

   // With the link disabled only configuration writes get in
   assign gate_wr = ~cfg.tx_enable & ~is_cfg_write(txwr_packet);
   assign gate_rd = ~cfg.tx_enable & ~is_cfg_write(txrd_packet);
   assign gate_rr = ~cfg.tx_enable & ~is_cfg_write(txrr_packet);

   assign elig_wr = txwr_access & ~gate_wr;
   assign elig_rd = txrd_access & ~gate_rd;
   assign elig_rr = txrr_access & ~gate_rr;
   assign any_req = elig_wr | elig_rd | elig_rr;

   // Held packet waits on its own class; config writes are consumed downstream
   assign arb_stall = arb_access & ~is_cfg_write(arb_packet) &
                      (arb_packet.write ? etx_wr_wait : etx_rd_wait);

   // Fixed priority with read response first and write last
   assign txrr_wait = arb_stall | gate_rr;
   assign txrd_wait = arb_stall | elig_rr | gate_rd;
   assign txwr_wait = arb_stall | elig_rr | elig_rd | gate_wr;

   always_comb begin
      if (elig_rr)
         sel_src = SRC_RR;
      else if (elig_rd)
         sel_src = SRC_RD;
      else
         sel_src = SRC_WR;  // Also the idle default
   end

   always_comb begin
      case (sel_src)
         SRC_RR:  sel_packet = txrr_packet;
         SRC_RD:  sel_packet = txrd_packet;
         default: sel_packet = txwr_packet;
      endcase
      if (cfg.ctrlmode_override && (sel_src != SRC_RR))
         sel_packet.ctrlmode = cfg.ctrlmode;  // Responses keep their ctrlmode
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         arb_access <= 1'b0;
         arb_rr     <= 1'b0;
      end else if (!arb_stall) begin
         arb_access <= any_req;                       // Bubble when idle
         arb_rr     <= any_req & (sel_src == SRC_RR);  // Bypass flag for remap
      end
   end

   always_ff @(posedge clk) begin
      if (!arb_stall && any_req)
         arb_packet <= sel_packet;
   end

   a_one_grant : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({txwr_access & ~txwr_wait, txrd_access & ~txrd_wait,
                txrr_access & ~txrr_wait}));

endmodule

`default_nettype wire

/* etx_cfg.sv */
`timescale 1ns/1ns
`default_nettype none

`include "etx_params.svh"

module etx_cfg
   import etx_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  logic          arb_access,
   input  logic          arb_rr,
   input  emesh_packet_t arb_packet,
   output logic          cfg_access,
   output emesh_packet_t cfg_packet,
   output logic          cfg_rr,
   output etx_cfg_t      cfg
);

   logic        cfg_hit;   // Register write addressed to this core
   logic [5:0]  reg_sel;   // Word offset inside the page
   logic [31:0] wr_data;

   assign cfg_hit = arb_access & is_cfg_write(arb_packet);
   assign reg_sel = arb_packet.dst_addr[7:2];
   assign wr_data = arb_packet.data;

   // Config writes stop here and all else flows on unchanged
   assign cfg_access = arb_access & ~cfg_hit;
   assign cfg_packet = arb_packet;
   assign cfg_rr     = arb_rr;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cfg <= '0;  // Link disabled with no remap and no override
      end else if (cfg_hit) begin
         case (reg_sel)
            `ETX_REG_CONFIG: begin
               cfg.tx_enable         <= wr_data[0];
               cfg.remap_enable      <= wr_data[1];
               cfg.ctrlmode_override <= wr_data[2];
               cfg.ctrlmode          <= wr_data[6:3];
            end
            `ETX_REG_REMAP: begin
               cfg.remap_sel     <= wr_data[11:0];
               cfg.remap_pattern <= wr_data[27:16];
            end
            default: begin
               // Write to an unknown offset is dropped
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* etx_core.sv */
`timescale 1ns/1ns
`default_nettype none

module etx_core
   import etx_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  logic          txwr_access,
   input  emesh_packet_t txwr_packet,
   output logic          txwr_wait,
   input  logic          txrd_access,
   input  emesh_packet_t txrd_packet,
   output logic          txrd_wait,
   input  logic          txrr_access,
   input  emesh_packet_t txrr_packet,
   output logic          txrr_wait,
   input  logic          tx_io_wait,
   input  logic          tx_rd_wait,
   input  logic          tx_wr_wait,
   output logic          tx_access,
   output logic          tx_burst,
   output emesh_packet_t tx_packet
);

   logic          arb_access;   // Arbiter stage
   emesh_packet_t arb_packet;
   logic          arb_rr;
   logic          cfg_access;   // After config decode
   emesh_packet_t cfg_packet;
   logic          cfg_rr;
   etx_cfg_t      cfg;
   logic          rmp_access;   // Remap stage
   emesh_packet_t rmp_packet;
   logic          etx_rd_wait;  // Back-pressure from the protocol stage
   logic          etx_wr_wait;

   etx_arbiter etx_arbiter_i (.clk, .rst_n,
      .txwr_access, .txwr_packet, .txwr_wait,
      .txrd_access, .txrd_packet, .txrd_wait,
      .txrr_access, .txrr_packet, .txrr_wait,
      .cfg, .etx_rd_wait, .etx_wr_wait,
      .arb_access, .arb_packet, .arb_rr);

   etx_cfg etx_cfg_i (.clk, .rst_n, .arb_access, .arb_rr, .arb_packet,
      .cfg_access, .cfg_packet, .cfg_rr, .cfg);

   etx_remap etx_remap_i (.clk, .rst_n, .cfg_access, .cfg_rr, .cfg_packet, .cfg,
      .etx_rd_wait, .etx_wr_wait, .rmp_access, .rmp_packet);

   etx_protocol etx_protocol_i (.clk, .rst_n, .rmp_access, .rmp_packet, .cfg,
      .tx_io_wait, .tx_rd_wait, .tx_wr_wait, .etx_rd_wait, .etx_wr_wait,
      .tx_access, .tx_burst, .tx_packet);

endmodule

`default_nettype wire

/* etx_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "etx_params.svh"

module etx_core_tb
   import etx_pkg::*;
();

   localparam int RAND_N = 30;                            // Random packets per source
   localparam int LIMIT  = (21 + 3 * RAND_N) * 20 + 200;  // Timeout in cycles

   logic          clk = 1'b0;
   logic          rst_n;
   logic          acc[3];       // Source ports, indexed by etx_src_e
   emesh_packet_t pkt_in[3];
   logic          wt[3];
   logic          tx_io_wait, tx_rd_wait, tx_wr_wait;
   logic          tx_access, tx_burst;
   emesh_packet_t tx_packet;
   etx_cfg_t      model_cfg;    // Registers as software wrote them
   emesh_packet_t exp_q[3][$];  // Expected link packets per source
   etx_src_e      order[$];     // Sources in link order
   int            cycle = 0;
   int            acc_cycle, tx_cycle;
   int            n_mismatch = 0, n_other = 0;
   int            n_burst = -1;  // Burst beats seen, idle while negative
   bit            traffic_done;

   always #2 clk = ~clk;

   etx_core etx_core_i (.clk, .rst_n,
      .txwr_access(acc[SRC_WR]), .txwr_packet(pkt_in[SRC_WR]), .txwr_wait(wt[SRC_WR]),
      .txrd_access(acc[SRC_RD]), .txrd_packet(pkt_in[SRC_RD]), .txrd_wait(wt[SRC_RD]),
      .txrr_access(acc[SRC_RR]), .txrr_packet(pkt_in[SRC_RR]), .txrr_wait(wt[SRC_RR]),
      .tx_io_wait, .tx_rd_wait, .tx_wr_wait, .tx_access, .tx_burst, .tx_packet);

   task automatic check(input logic [102:0] got, want, input string what);
      if (got !== want) begin
         $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, want);
         n_mismatch++;
      end
   endtask

   task automatic finish_run();
      $display("Errors: %0d mismatches, %0d other", n_mismatch, n_other);
      if (n_mismatch == 0 && n_other == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   endtask

   // Link packet for p taken from src under configuration c
   function automatic emesh_packet_t ref_pkt(emesh_packet_t p, etx_src_e src, etx_cfg_t c);
      if (src == SRC_RR)
         return p;  // Responses go out untouched
      if (c.ctrlmode_override)
         p.ctrlmode = c.ctrlmode;
      for (int i = 0; i < 12; i++)
         if (c.remap_enable && c.remap_sel[i])
            p.dst_addr[20 + i] = c.remap_pattern[i];  // Selected ID bit replaced
      return p;
   endfunction

   function automatic emesh_packet_t rand_pkt(etx_src_e src);
      emesh_packet_t p;
      p = {1'b0, 2'($urandom), 4'($urandom), $urandom, $urandom, 30'($urandom), src};
      p.write = (src != SRC_RD);  // Read responses travel as writes
      p.dst_addr[19] = 1'b0;      // Never the configuration page
      return p;
   endfunction

   // Starts at a falling edge, holds until taken, ends at the next falling edge
   task automatic send(etx_src_e src, emesh_packet_t p, bit to_link = 1'b1);
      acc[src] = 1'b1;
      pkt_in[src] = p;
      do
         @(posedge clk);
      while (wt[src]);
      acc_cycle = cycle;
      if (to_link)
         exp_q[src].push_back(ref_pkt(p, src, model_cfg));
      @(negedge clk);
      acc[src] = 1'b0;
   endtask

   task automatic write_cfg(logic [5:0] offset, logic [31:0] value);
      send(SRC_WR, {1'b1, 2'b10, 4'h0, `ETX_ID, `ETX_CFG_PAGE, 8'h00, offset, 2'b00,
                    value, 32'h0}, 1'b0);
      if (offset == `ETX_REG_CONFIG)
         {model_cfg.ctrlmode, model_cfg.ctrlmode_override, model_cfg.remap_enable,
          model_cfg.tx_enable} = value[6:0];
      else
         {model_cfg.remap_pattern, model_cfg.remap_sel} = {value[27:16], value[11:0]};
      repeat (3) @(negedge clk);  // New values reach the arbiter
   endtask

   task automatic traffic(etx_src_e src);
      repeat (RAND_N) begin
         repeat ($urandom % 3) @(negedge clk);  // Random gap
         send(src, rand_pkt(src));
      end
   endtask

   task automatic drain();
      repeat (200)
         if (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0)
            @(negedge clk);
      for (int s = 0; s < 3; s++)
         if (exp_q[s].size() != 0) begin
            $display("Error: %0d packets of source %0d never reached the link",
                     exp_q[s].size(), s);
            n_other++;
            exp_q[s].delete();
         end
      repeat (4) @(negedge clk);  // Idle gap before the next test
   endtask

   // Link takes a packet when access is high and its wait class is low
   always @(posedge clk) begin : monitor
      etx_src_e      src;
      emesh_packet_t want;
      if (rst_n && tx_access && !(tx_io_wait || (tx_packet.write ? tx_wr_wait : tx_rd_wait))) begin
         src = etx_src_e'(tx_packet.src_addr[1:0]);  // Source tag
         tx_cycle = cycle;
         order.push_back(src);
         if (tx_packet.src_addr[1:0] == 2'd3 || exp_q[src].size() == 0) begin
            $display("Error at %0t ns: unexpected packet %h on the link", $time, tx_packet);
            n_other++;
         end else begin
            want = exp_q[src].pop_front();
            check(tx_packet, want, $sformatf("%s packet", src.name()));
         end
         if (n_burst >= 0 && tx_packet.write) begin
            check(103'(tx_burst), 103'(n_burst != 0), "tx_burst");  // First beat starts it
            n_burst++;
         end
      end
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= LIMIT) begin
         $display("Error: run did not finish within %0d cycles", LIMIT);
         n_other++;
         finish_run();
      end
   end

   initial begin
      emesh_packet_t p;
      void'($urandom(74071));
      rst_n = 1'b0;
      acc = '{default: 1'b0};
      pkt_in = '{default: '0};
      {tx_io_wait, tx_rd_wait, tx_wr_wait} = 3'b000;
      model_cfg = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check(103'({tx_access, tx_burst}), 103'(0), "link outputs after reset");

      // Link still disabled, the read is held off and then withdrawn
      acc[SRC_RD] = 1'b1;
      pkt_in[SRC_RD] = rand_pkt(SRC_RD);
      repeat (20) begin
         @(posedge clk);
         check(103'({wt[0], wt[1], wt[2]}), 103'(3'b111), "source waits before enable");
      end
      @(negedge clk);
      acc[SRC_RD] = 1'b0;
      write_cfg(`ETX_REG_CONFIG, 32'h1);

      for (int s = 0; s < 3; s++) begin
         send(etx_src_e'(s), rand_pkt(etx_src_e'(s)));
         drain();
         check(103'(tx_cycle - acc_cycle), 103'(3), "latency");  // Three register stages
      end

      order.delete();
      fork
         send(SRC_WR, rand_pkt(SRC_WR));
         send(SRC_RD, rand_pkt(SRC_RD));
         send(SRC_RR, rand_pkt(SRC_RR));
      join
      drain();
      check(103'({order[0], order[1], order[2]}), 103'({SRC_RR, SRC_RD, SRC_WR}), "priority");

      write_cfg(`ETX_REG_REMAP, {4'h0, 12'hA50, 4'h0, 12'hF0F});
      write_cfg(`ETX_REG_CONFIG, 32'h2F);  // Enable, remap, override to ctrlmode 5
      for (int s = 0; s < 3; s++)
         send(etx_src_e'(s), rand_pkt(etx_src_e'(s)));
      drain();

      traffic_done = 1'b0;
      fork
         begin
            fork
               traffic(SRC_WR);
               traffic(SRC_RD);
               traffic(SRC_RR);
            join
            traffic_done = 1'b1;
         end
         while (!traffic_done) begin
            @(negedge clk);
            tx_io_wait = ($urandom % 8) == 0;
            tx_rd_wait = ($urandom % 4) == 0;
            tx_wr_wait = ($urandom % 4) == 0;
         end
      join
      {tx_io_wait, tx_rd_wait, tx_wr_wait} = 3'b000;
      drain();

      n_burst = 0;
      for (int i = 0; i < 8; i++) begin
         p = rand_pkt(SRC_WR);
         p.datamode = 2'b10;                    // Word writes
         p.dst_addr = 32'h0004_0000 + 4 * i;    // Consecutive addresses
         send(SRC_WR, p);
      end
      drain();
      check(103'(n_burst), 103'(8), "burst beats");
      finish_run();
   end

endmodule

`default_nettype wire

/* etx_params.svh */
`ifndef ETX_PARAMS_SVH
`define ETX_PARAMS_SVH

// Chip ID, matched against dst_addr[31:20]
`define ETX_ID 12'h810

// Page in dst_addr[19:16] that selects the configuration space
`define ETX_CFG_PAGE 4'hF

// Register offsets, compared with dst_addr[7:2]
`define ETX_REG_CONFIG 6'h00  // Enable, remap enable, override, ctrlmode
`define ETX_REG_REMAP 6'h01   // Remap select and pattern

// Burst detection
`define ETX_DATAMODE_WORD 2'b10  // Only word writes can burst
`define ETX_BURST_STRIDE 32'd4   // Address step between burst beats

`endif

/* etx_pkg.sv */
`default_nettype none

`include "etx_params.svh"

package etx_pkg;

   // Mesh packet, first field is the MSB
   typedef struct packed {
      logic        write;     // 1 for write, 0 for read
      logic [1:0]  datamode;  // Transfer size
      logic [3:0]  ctrlmode;  // Routing and control hints
      logic [31:0] dst_addr;
      logic [31:0] data;
      logic [31:0] src_addr;  // Return address for reads
   } emesh_packet_t;

   // Configuration register contents
   typedef struct packed {
      logic        tx_enable;          // Link transmit enable
      logic        remap_enable;       // Destination remap on
      logic        ctrlmode_override;  // Force ctrlmode on new requests
      logic [3:0]  ctrlmode;           // Forced value
      logic [11:0] remap_sel;          // Bits of dst_addr[31:20] to replace
      logic [11:0] remap_pattern;      // Replacement bits
   } etx_cfg_t;

   // Transmit sources
   typedef enum logic [1:0] {
      SRC_WR,  // Write request
      SRC_RD,  // Read request
      SRC_RR   // Read response
   } etx_src_e;

   // Write into this chip's configuration page
   function automatic logic is_cfg_write(emesh_packet_t pkt);
      return pkt.write && (pkt.dst_addr[31:20] == `ETX_ID) &&
             (pkt.dst_addr[19:16] == `ETX_CFG_PAGE);
   endfunction

endpackage

`default_nettype wire

/* etx_protocol.sv */
`timescale 1ns/1ns
`default_nettype none

`include "etx_params.svh"

module etx_protocol
   import etx_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  logic          rmp_access,
   input  emesh_packet_t rmp_packet,
   input  etx_cfg_t      cfg,
   input  logic          tx_io_wait,
   input  logic          tx_rd_wait,
   input  logic          tx_wr_wait,
   output logic          etx_rd_wait,
   output logic          etx_wr_wait,
   output logic          tx_access,
   output logic          tx_burst,
   output emesh_packet_t tx_packet
);

   logic out_stall;     // Output register held by the link
   logic base_wr_wait;  // Writes may not enter the output register
   logic base_rd_wait;  // Reads may not enter the output register
   logic rmp_stall;     // Remap stage cannot hand over
   logic rmp_move;      // Remap packet loads this cycle
   logic burst_hit;     // Continues the word write now on the link

   // A stuck output register blocks both classes behind it
   assign out_stall = tx_access &
                      (tx_io_wait | (tx_packet.write ? tx_wr_wait : tx_rd_wait));

   // Disabled link shuts the gate for everything
   assign base_wr_wait = tx_io_wait | tx_wr_wait | ~cfg.tx_enable | out_stall;
   assign base_rd_wait = tx_io_wait | tx_rd_wait | ~cfg.tx_enable | out_stall;

   assign rmp_stall = rmp_access & (rmp_packet.write ? base_wr_wait : base_rd_wait);
   assign rmp_move  = rmp_access & ~rmp_stall;

   // Remap stall folded in so the arbiter never overruns a full remap stage
   assign etx_wr_wait = base_wr_wait | rmp_stall;
   assign etx_rd_wait = base_rd_wait | rmp_stall;

   // Back-to-back word writes at consecutive addresses
   assign burst_hit = rmp_packet.write & (rmp_packet.datamode == `ETX_DATAMODE_WORD) &
                      tx_access & tx_packet.write &
                      (tx_packet.datamode == `ETX_DATAMODE_WORD) &
                      (rmp_packet.dst_addr == tx_packet.dst_addr + `ETX_BURST_STRIDE);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_access <= 1'b0;
         tx_burst  <= 1'b0;
      end else if (!out_stall) begin
         tx_access <= rmp_move;              // Bubble ends a burst
         tx_burst  <= rmp_move & burst_hit;
      end
   end

   always_ff @(posedge clk) begin
      if (!out_stall && rmp_move)
         tx_packet <= rmp_packet;
   end

   a_tx_hold : assert property (@(posedge clk) disable iff (!rst_n)
      out_stall |=> (tx_access && $stable(tx_packet)));

endmodule

`default_nettype wire

/* etx_remap.sv */
`timescale 1ns/1ns
`default_nettype none

module etx_remap
   import etx_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  logic          cfg_access,
   input  logic          cfg_rr,
   input  emesh_packet_t cfg_packet,
   input  etx_cfg_t      cfg,
   input  logic          etx_rd_wait,
   input  logic          etx_wr_wait,
   output logic          rmp_access,
   output emesh_packet_t rmp_packet
);

   emesh_packet_t rmp_next;  // Packet after address rewrite
   logic          in_move;   // Upstream packet leaves its stage
   logic          rmp_stall; // Held packet blocked

   always_comb begin
      rmp_next = cfg_packet;
      if (cfg.remap_enable && !cfg_rr)
         rmp_next.dst_addr[31:20] = (cfg_packet.dst_addr[31:20] & ~cfg.remap_sel) |
                                    (cfg.remap_pattern & cfg.remap_sel);
   end

   assign in_move   = cfg_access & ~(cfg_packet.write ? etx_wr_wait : etx_rd_wait);
   assign rmp_stall = rmp_access & (rmp_packet.write ? etx_wr_wait : etx_rd_wait);

   always_ff @(posedge clk) begin
      if (!rst_n)
         rmp_access <= 1'b0;
      else if (!rmp_stall)
         rmp_access <= in_move;
   end

   always_ff @(posedge clk) begin
      if (!rmp_stall && in_move)
         rmp_packet <= rmp_next;
   end

   a_rmp_hold : assert property (@(posedge clk) disable iff (!rst_n)
      rmp_stall |=> (rmp_access && $stable(rmp_packet)));

endmodule

`default_nettype wire

/* files.f */
+incdir+.
etx_pkg.sv
etx_arbiter.sv
etx_cfg.sv
etx_remap.sv
etx_protocol.sv
etx_core.sv
etx_core_tb.sv
